//--- verilog/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define XLEN 32

// data memory depth in words
`define DMEM_WORDS 256

// extra cycles the memory takes before ready
`define DMEM_WAIT 2

`endif

//--- verilog/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

  // one-hot load/store operation
  typedef struct packed {
    logic lb;
    logic lbu;
    logic lh;
    logic lhu;
    logic lw;
    logic sb;
    logic sh;
    logic sw;
  } lsu_op_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic valid;
    logic wren;
    logic [4:0] waddr;
    logic [`XLEN-1:0] wdata;
    logic load;
    logic store;
    logic fence;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] sdata;
    lsu_op_t lsu_op;
  } exec_out_t;

  typedef struct packed {
    logic mem_valid;
    logic mem_fence;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    logic [3:0] mem_wstrb;
  } mem_req_t;

  typedef struct packed {
    logic mem_ready;
    logic [`XLEN-1:0] mem_rdata;
  } mem_rsp_t;

  // bypass toward execute
  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [`XLEN-1:0] wdata;
  } fwd_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic valid;
    logic wren;
    logic [4:0] waddr;
    logic [`XLEN-1:0] wdata;
    logic fence;
  } wb_out_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic valid;
    logic wren;
    logic [4:0] waddr;
    logic [`XLEN-1:0] wdata;
    logic load;
    logic store;
    logic fence;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] sdata;
    lsu_op_t lsu_op;
    // request still to be sent from the held copy
    logic replay;
    // reply due for an instruction that was cleared
    logic orphan;
  } mem_stage_reg_t;

  localparam mem_stage_reg_t init_mem_stage_reg = '{
    pc: '0,
    valid: 1'b0,
    wren: 1'b0,
    waddr: '0,
    wdata: '0,
    load: 1'b0,
    store: 1'b0,
    fence: 1'b0,
    address: '0,
    sdata: '0,
    lsu_op: '0,
    replay: 1'b0,
    orphan: 1'b0
  };

  // replicate byte or halfword across the word
  function automatic logic [`XLEN-1:0] store_data(input logic [`XLEN-1:0] sdata,
                                                  input lsu_op_t op);
    logic [`XLEN-1:0] res;
    res = sdata;
    if (op.sb) begin
      res = {4{sdata[7:0]}};
    end else if (op.sh) begin
      res = {2{sdata[15:0]}};
    end
    return res;
  endfunction

  function automatic logic [`XLEN-1:0] load_data(input logic [`XLEN-1:0] rdata,
                                                 input logic [1:0] offset,
                                                 input lsu_op_t op);
    logic [7:0] b;
    logic [15:0] h;
    logic [`XLEN-1:0] res;
    b = rdata[8*offset +: 8];
    h = rdata[16*offset[1] +: 16];
    if (op.lb) begin
      res = {{(`XLEN-8){b[7]}}, b};
    end else if (op.lbu) begin
      res = {{(`XLEN-8){1'b0}}, b};
    end else if (op.lh) begin
      res = {{(`XLEN-16){h[15]}}, h};
    end else if (op.lhu) begin
      res = {{(`XLEN-16){1'b0}}, h};
    end else begin
      res = rdata;
    end
    return res;
  endfunction

endpackage

//--- verilog/lsu_align.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module lsu_align (
  input logic [`XLEN-1:0] address,
  input logic [`XLEN-1:0] sdata,
  input mem_pkg::lsu_op_t lsu_op,
  input logic [`XLEN-1:0] rdata,
  output logic [`XLEN-1:0] wdata,
  output logic [3:0] wstrb,
  output logic [`XLEN-1:0] ldata
);
  import mem_pkg::*;

  logic [1:0] offset;

  // byte offset inside the word
  assign offset = address[1:0];

  assign wdata = store_data(sdata, lsu_op);

  // strobes only for stores, loads and fences write nothing
  always_comb begin
    wstrb = 4'b0000;
    if (lsu_op.sw) begin
      wstrb = 4'b1111;
    end else if (lsu_op.sh) begin
      if (offset[1]) begin
        wstrb = 4'b1100;
      end else begin
        wstrb = 4'b0011;
      end
    end else if (lsu_op.sb) begin
      case (offset)
        2'd0: wstrb = 4'b0001;
        2'd1: wstrb = 4'b0010;
        2'd2: wstrb = 4'b0100;
        default: wstrb = 4'b1000;
      endcase
    end
  end

  // pick the lane at the offset, then sign or zero extend
  assign ldata = load_data(rdata, offset, lsu_op);

endmodule

//--- verilog/data_memory.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module data_memory (
  input logic clock,
  input logic reset,
  input mem_pkg::mem_req_t req,
  output mem_pkg::mem_rsp_t rsp
);
  import mem_pkg::*;

  localparam int AW = $clog2(`DMEM_WORDS);
  localparam int CW = $clog2(`DMEM_WAIT + 2);

  logic [`XLEN-1:0] mem [`DMEM_WORDS];
  logic [`XLEN-1:0] rdata;
  logic [AW-1:0] index;
  logic [CW-1:0] count;
  logic busy;
  logic last;
  logic accept;

  // word address
  assign index = req.mem_addr[AW+1:2];

  // final busy cycle, ready goes out here
  assign last = busy && (count == '0);

  // free again in its ready cycle
  assign accept = req.mem_valid && (!busy || last);

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy <= 1'b0;
      count <= '0;
    end else begin
      if (accept) begin
        busy <= 1'b1;
        count <= CW'(`DMEM_WAIT);
      end else if (last) begin
        busy <= 1'b0;
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  // read data captured at acceptance and held until ready
  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= mem[index];
      if (!req.mem_fence) begin
        for (int i = 0; i < 4; i++) begin
          if (req.mem_wstrb[i]) begin
            mem[index][8*i +: 8] <= req.mem_wdata[8*i +: 8];
          end
        end
      end
    end
  end

  assign rsp.mem_ready = last;
  assign rsp.mem_rdata = rdata;

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module memory_stage (
  input logic clock,
  input logic reset,
  input mem_pkg::exec_out_t ex_in,
  input logic clear,
  output mem_pkg::mem_req_t dmem_req,
  input mem_pkg::mem_rsp_t dmem_rsp,
  output logic stall,
  output mem_pkg::fwd_t fwd,
  output mem_pkg::wb_out_t wb
);
  import mem_pkg::*;

  mem_stage_reg_t r;
  mem_stage_reg_t rin;

  logic ex_mem;
  logic r_mem;
  logic pending;
  logic can_accept;
  logic ex_issue;
  logic ready_mine;
  logic stall_raw;
  logic kill;

  logic [`XLEN-1:0] lsu_address;
  logic [`XLEN-1:0] lsu_sdata;
  lsu_op_t lsu_sel_op;
  logic [`XLEN-1:0] lsu_wdata;
  logic [3:0] lsu_wstrb;
  logic [`XLEN-1:0] lsu_ldata;
  logic [`XLEN-1:0] result;

  assign ex_mem = ex_in.load | ex_in.store | ex_in.fence;
  assign r_mem = r.load | r.store | r.fence;

  // memory busy with a reply for us or for a killed instruction
  assign pending = r.orphan | (r_mem & ~r.replay);
  assign can_accept = ~pending | (r.orphan & dmem_rsp.mem_ready);

  // a reply owed to a cleared instruction is not ours
  assign ready_mine = dmem_rsp.mem_ready & ~r.orphan;

  assign stall_raw = r_mem & (r.replay | ~ready_mine);
  assign stall = stall_raw & ~clear;
  assign kill = stall_raw | clear;

  assign ex_issue = ~r.replay & ex_mem & can_accept;

  // alignment follows the held instruction while one is in the stage
  always_comb begin
    if (r_mem) begin
      lsu_address = r.address;
      lsu_sdata = r.sdata;
      lsu_sel_op = r.lsu_op;
    end else begin
      lsu_address = ex_in.address;
      lsu_sdata = ex_in.sdata;
      lsu_sel_op = ex_in.lsu_op;
    end
  end

  lsu_align u_lsu_align (
    .address(lsu_address),
    .sdata(lsu_sdata),
    .lsu_op(lsu_sel_op),
    .rdata(dmem_rsp.mem_rdata),
    .wdata(lsu_wdata),
    .wstrb(lsu_wstrb),
    .ldata(lsu_ldata)
  );

  // replayed request from the held copy, otherwise straight from execute
  always_comb begin
    if (r.replay) begin
      dmem_req.mem_valid = can_accept;
      dmem_req.mem_fence = r.fence;
      dmem_req.mem_addr = r.address;
    end else begin
      dmem_req.mem_valid = ex_issue;
      dmem_req.mem_fence = ex_in.fence;
      dmem_req.mem_addr = ex_in.address;
    end
    dmem_req.mem_wdata = lsu_wdata;
    dmem_req.mem_wstrb = lsu_wstrb;
  end

  always_comb begin
    rin = r;
    if (stall == 0) begin
      rin.pc = ex_in.pc;
      rin.valid = ex_in.valid;
      rin.wren = ex_in.wren;
      rin.waddr = ex_in.waddr;
      rin.wdata = ex_in.wdata;
      rin.load = ex_in.load;
      rin.store = ex_in.store;
      rin.fence = ex_in.fence;
      rin.address = ex_in.address;
      rin.sdata = ex_in.sdata;
      rin.lsu_op = ex_in.lsu_op;
      rin.replay = ex_mem & ~ex_issue;
    end else begin
      rin.replay = r.replay & ~dmem_req.mem_valid;
    end
    // killed while its request is in flight, or sent this very cycle
    rin.orphan = (r.orphan & ~dmem_rsp.mem_ready) |
                 (clear & r_mem & ((~r.replay & ~ready_mine) |
                                   (r.replay & dmem_req.mem_valid)));
  end

  assign result = r.load ? lsu_ldata : r.wdata;

  assign fwd.wren = r.wren & ~kill;
  assign fwd.waddr = r.waddr;
  assign fwd.wdata = result;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r <= init_mem_stage_reg;
    end else begin
      r <= rin;
    end
  end

  // writeback register, payload unreset
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      wb.valid <= 1'b0;
      wb.wren <= 1'b0;
      wb.fence <= 1'b0;
    end else begin
      wb.valid <= r.valid & ~kill;
      wb.wren <= r.wren & ~kill;
      wb.fence <= r.fence & ~kill;
    end
    wb.pc <= r.pc;
    wb.waddr <= r.waddr;
    wb.wdata <= result;
  end

endmodule

//--- verilog/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem (
  input logic clock,
  input logic reset,
  input mem_pkg::exec_out_t ex_in,
  input logic clear,
  output logic stall,
  output mem_pkg::fwd_t fwd,
  output mem_pkg::wb_out_t wb
);
  import mem_pkg::*;

  // stage to memory
  mem_req_t dmem_req;
  mem_rsp_t dmem_rsp;

  memory_stage u_memory_stage (
    .clock(clock),
    .reset(reset),
    .ex_in(ex_in),
    .clear(clear),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp),
    .stall(stall),
    .fwd(fwd),
    .wb(wb)
  );

  data_memory u_data_memory (
    .clock(clock),
    .reset(reset),
    .req(dmem_req),
    .rsp(dmem_rsp)
  );

endmodule

//--- sim/mem_subsystem_asserts.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module mem_subsystem_asserts (
  input logic clock,
  input logic reset,
  input logic stall,
  input mem_pkg::mem_req_t dmem_req,
  input mem_pkg::mem_rsp_t dmem_rsp
);

  // a memory access holds the stage only for a bounded time
  property stall_bounded;
    @(posedge clock) disable iff (reset == 0)
      stall |-> ##[1:(`DMEM_WAIT + 2)] !stall;
  endproperty

  // a request only goes out when the memory can take it
  property request_answered;
    @(posedge clock) disable iff (reset == 0)
      dmem_req.mem_valid |-> ##(`DMEM_WAIT + 1) dmem_rsp.mem_ready;
  endproperty

  // ready is a single cycle pulse
  property ready_pulse;
    @(posedge clock) disable iff (reset == 0)
      dmem_rsp.mem_ready |=> !dmem_rsp.mem_ready;
  endproperty

  assert property (stall_bounded)
    else $error("stall held longer than %0d cycles", `DMEM_WAIT + 2);
  assert property (request_answered)
    else $error("request not answered after %0d cycles", `DMEM_WAIT + 1);
  assert property (ready_pulse)
    else $error("mem_ready high for more than one cycle");

endmodule

bind memory_stage mem_subsystem_asserts u_asserts (
  .clock(clock),
  .reset(reset),
  .stall(stall),
  .dmem_req(dmem_req),
  .dmem_rsp(dmem_rsp)
);

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int wait_limit = 10 * (`DMEM_WAIT + 2);
  localparam int k_lb = 0;
  localparam int k_lbu = 1;
  localparam int k_lh = 2;
  localparam int k_lhu = 3;
  localparam int k_lw = 4;

  logic clock;
  logic reset;
  logic clear;
  exec_out_t ex_in;
  logic stall;
  fwd_t fwd;
  wb_out_t wb;

  int seed = 62;
  int errors = 0;
  logic [31:0] pc_count = 32'h100;
  // byte-wide shadow of the data memory
  logic [7:0] shadow [`DMEM_WORDS*4];
  wb_out_t exp_q [$];

  mem_subsystem dut (
    .clock(clock),
    .reset(reset),
    .ex_in(ex_in),
    .clear(clear),
    .stall(stall),
    .fwd(fwd),
    .wb(wb)
  );

  always #50 clock = ~clock;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  function automatic logic [31:0] rand_word_addr();
    logic [31:0] r;
    r = $random(seed);
    return r & (`DMEM_WORDS*4 - 4);
  endfunction

  function automatic exec_out_t alu_op(input logic [4:0] rd, input logic [31:0] value);
    exec_out_t i;
    i = '0;
    i.valid = 1'b1;
    i.wren = 1'b1;
    i.waddr = rd;
    i.wdata = value;
    return i;
  endfunction

  function automatic exec_out_t load_op(input int kind, input logic [31:0] addr,
                                        input logic [4:0] rd);
    exec_out_t i;
    i = alu_op(rd, addr);
    i.load = 1'b1;
    i.address = addr;
    i.lsu_op.lb = (kind == k_lb);
    i.lsu_op.lbu = (kind == k_lbu);
    i.lsu_op.lh = (kind == k_lh);
    i.lsu_op.lhu = (kind == k_lhu);
    i.lsu_op.lw = (kind == k_lw);
    return i;
  endfunction

  function automatic exec_out_t store_op(input int size, input logic [31:0] addr,
                                         input logic [31:0] data);
    exec_out_t i;
    i = alu_op(5'd0, addr);
    i.wren = 1'b0;
    i.store = 1'b1;
    i.address = addr;
    i.sdata = data;
    i.lsu_op.sb = (size == 1);
    i.lsu_op.sh = (size == 2);
    i.lsu_op.sw = (size == 4);
    return i;
  endfunction

  // load result rebuilt from the little endian shadow bytes
  function automatic logic [31:0] expect_load(input lsu_op_t op, input logic [31:0] addr);
    logic [7:0] b0;
    logic [7:0] b1;
    int a;
    a = int'(addr);
    b0 = shadow[a];
    b1 = shadow[a + 1];
    if (op.lb) begin
      return {{24{b0[7]}}, b0};
    end else if (op.lbu) begin
      return {24'h0, b0};
    end else if (op.lh) begin
      return {{16{b1[7]}}, b1, b0};
    end else if (op.lhu) begin
      return {16'h0, b1, b0};
    end
    return {shadow[a + 3], shadow[a + 2], b1, b0};
  endfunction

  task automatic record(input exec_out_t i, input logic expect_wb);
    wb_out_t e;
    int a;
    a = int'(i.address);
    if (i.store) begin
      for (int k = 0; k < 4; k++) begin
        if (i.lsu_op.sw || (i.lsu_op.sh && k < 2) || k == 0) begin
          shadow[a + k] = i.sdata[8*k +: 8];
        end
      end
    end
    if (expect_wb) begin
      e.pc = i.pc;
      e.valid = 1'b1;
      e.wren = i.wren;
      e.waddr = i.waddr;
      e.wdata = i.load ? expect_load(i.lsu_op, i.address) : i.wdata;
      e.fence = i.fence;
      exp_q.push_back(e);
    end
  endtask

  task automatic present(input exec_out_t instr, input logic expect_wb);
    exec_out_t i;
    i = instr;
    i.pc = pc_count;
    pc_count = pc_count + 4;
    @(posedge clock);
    ex_in <= i;
    record(i, expect_wb);
  endtask

  // returns at the negedge before the edge that takes ex_in
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clock);
    while (stall !== 1'b0 && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    check_true(stall === 1'b0, "stall did not fall before the timeout");
  endtask

  task automatic send(input exec_out_t instr, input logic expect_wb);
    present(instr, expect_wb);
    wait_accept();
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(posedge clock);
    ex_in <= '0;
    while (exp_q.size() != 0 && n < wait_limit) begin
      @(posedge clock);
      n++;
    end
    check_true(exp_q.size() == 0, "timed out waiting for writebacks");
    exp_q.delete();
    // a stray writeback would still show up here
    repeat (2) @(posedge clock);
  endtask

  task automatic test_reset_alu();
    check_true(stall === 1'b0 && wb.valid === 1'b0, "stall or wb.valid high after reset");
    check_true(fwd.wren === 1'b0 && wb.wren === 1'b0, "wren high after reset");
    send(alu_op(5'd3, 32'h1234_5678), 1'b1);
    @(posedge clock);
    ex_in <= '0;
    @(negedge clock);
    check_val("fwd.wren", fwd.wren, 1);
    check_val("fwd.waddr", fwd.waddr, 3);
    check_val("fwd.wdata", fwd.wdata, 32'h1234_5678);
    check_val("wb.valid", wb.valid, 0);
    @(negedge clock);
    check_val("wb.valid", wb.valid, 1);
    check_val("wb.waddr", wb.waddr, 3);
    check_val("wb.wdata", wb.wdata, 32'h1234_5678);
    drain();
  endtask

  task automatic test_word_round_trip();
    logic [31:0] addrs [16];
    logic [31:0] value;
    for (int n = 0; n < 16; n++) begin
      addrs[n] = rand_word_addr();
      value = $random(seed);
      send(store_op(4, addrs[n], value), 1'b1);
    end
    for (int n = 0; n < 16; n++) begin
      send(load_op(k_lw, addrs[n], 5'(n + 1)), 1'b1);
    end
    drain();
  endtask

  task automatic test_subword();
    logic [31:0] base;
    logic [31:0] r;
    for (int w = 0; w < 2; w++) begin
      base = rand_word_addr();
      r = $random(seed);
      send(store_op(4, base, r), 1'b1);
      for (int off = 0; off < 4; off++) begin
        r = $random(seed);
        // mix of sign bits across the lanes
        r[7] = off[0];
        send(store_op(1, base + off, r), 1'b1);
      end
      for (int off = 0; off < 4; off++) begin
        send(load_op(k_lb, base + off, 5'(off + 1)), 1'b1);
        send(load_op(k_lbu, base + off, 5'(off + 5)), 1'b1);
      end
      r = $random(seed);
      r[15] = 1'b1;
      send(store_op(2, base + 2, r), 1'b1);
      for (int off = 0; off < 4; off += 2) begin
        send(load_op(k_lh, base + off, 5'(off + 12)), 1'b1);
        send(load_op(k_lhu, base + off, 5'(off + 13)), 1'b1);
      end
      send(load_op(k_lw, base, 5'd20), 1'b1);
    end
    drain();
  endtask

  task automatic test_stall();
    logic [31:0] a;
    logic [31:0] value;
    int rises;
    int falls;
    int n;
    logic prev;
    a = rand_word_addr();
    value = $random(seed);
    send(store_op(4, a, value), 1'b1);
    drain();
    send(load_op(k_lw, a, 5'd7), 1'b1);
    // ALU op held on ex_in behind the load
    present(alu_op(5'd8, 32'h0bad_cafe), 1'b1);
    rises = 0;
    falls = 0;
    n = 0;
    prev = 1'b0;
    while (falls == 0 && n < wait_limit) begin
      @(negedge clock);
      n++;
      if (stall && !prev) begin
        rises++;
      end
      if (!stall && prev) begin
        falls++;
      end
      if (stall) begin
        check_val("fwd.wren", fwd.wren, 0);
      end
      check_val("wb.valid", wb.valid, 0);
      prev = stall;
    end
    check_true(rises == 1 && falls == 1, "stall did not rise and fall once during the load");
    check_val("fwd.wren", fwd.wren, 1);
    check_val("fwd.wdata", fwd.wdata, value);
    drain();
  endtask

  task automatic test_clear();
    logic [31:0] a;
    logic [31:0] value;
    a = rand_word_addr();
    value = $random(seed);
    send(store_op(4, a, value), 1'b1);
    drain();
    send(load_op(k_lw, a, 5'd9), 1'b0);
    @(posedge clock);
    ex_in <= '0;
    @(negedge clock);
    check_true(stall, "stall did not rise for the load to be cleared");
    // next load taken while the killed reply is still due
    present(load_op(k_lw, a, 5'd10), 1'b1);
    clear <= 1'b1;
    @(negedge clock);
    check_true(!stall, "stall stayed high during clear");
    @(posedge clock);
    clear <= 1'b0;
    ex_in <= '0;
    drain();
  endtask

  task automatic test_fence();
    exec_out_t f;
    logic [31:0] a;
    logic [31:0] value;
    a = rand_word_addr();
    value = $random(seed);
    send(store_op(4, a, value), 1'b1);
    drain();
    f = alu_op(5'd0, 32'h0);
    f.wren = 1'b0;
    f.fence = 1'b1;
    f.address = a;
    send(f, 1'b1);
    @(posedge clock);
    ex_in <= '0;
    @(negedge clock);
    check_true(stall, "fence did not stall");
    wait_accept();
    send(load_op(k_lw, a, 5'd11), 1'b1);
    drain();
  endtask

  // writebacks must match the issued instructions in order
  always @(negedge clock) begin : wb_monitor
    wb_out_t e;
    if (reset && wb.valid) begin
      if (exp_q.size() == 0) begin
        check_true(1'b0, "writeback seen with no instruction outstanding");
      end else begin
        e = exp_q.pop_front();
        check_val("wb.pc", wb.pc, e.pc);
        check_val("wb.wren", wb.wren, e.wren);
        check_val("wb.waddr", wb.waddr, e.waddr);
        check_val("wb.wdata", wb.wdata, e.wdata);
        check_val("wb.fence", wb.fence, e.fence);
      end
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    clear = 1'b0;
    ex_in = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    test_reset_alu();
    test_word_round_trip();
    test_subword();
    test_stall();
    test_clear();
    test_fence();
    $display("simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/lsu_align.sv
verilog/data_memory.sv
verilog/memory_stage.sv
verilog/mem_subsystem.sv
sim/mem_subsystem_asserts.sv
sim/tb_mem_subsystem.sv
